//--- include/tti_queue_consts.svh
// Queue bank sizes, CSR widths, reset threshold and status word bit positions
`ifndef TTI_QUEUE_CONSTS_SVH
`define TTI_QUEUE_CONSTS_SVH

`define TTI_QUEUE_NUM 4
`define TTI_QUEUE_DEPTH 8
`define TTI_DEPTH_W 4
`define TTI_DATA_W 32
`define TTI_CSR_AW 6
`define TTI_THLD_RST 1

// STATUS read word layout, depth sits in the low bits
`define TTI_STAT_EMPTY_BIT 8
`define TTI_STAT_FULL_BIT 9
`define TTI_STAT_TRIG_BIT 10
`define TTI_STAT_INTR_BIT 16

`endif

//--- source/tti_queue_pkg.sv
// Queue opcode and register selector enums, CSR request/response, queue command and status structs
`include "tti_queue_consts.svh"

package tti_queue_pkg;

  typedef enum logic [1:0] {
    QOP_NONE,
    QOP_PUSH,
    QOP_SET_THLD,
    QOP_FLUSH
  } queue_op_e;

  // Selected by CSR address bits 3:2
  typedef enum logic [1:0] {
    REG_DATA   = 2'd0,
    REG_THLD   = 2'd1,
    REG_RST    = 2'd2,
    REG_STATUS = 2'd3
  } csr_reg_e;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`TTI_CSR_AW-1:0] addr;
    logic [`TTI_DATA_W-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                   rd_ack;
    logic                   wr_ack;
    logic [`TTI_DATA_W-1:0] rd_data;
  } csr_rsp_t;

  typedef struct packed {
    queue_op_e              op;
    logic [`TTI_DATA_W-1:0] data;
  } queue_cmd_t;

  typedef struct packed {
    logic [`TTI_DEPTH_W-1:0] depth;
    logic                    empty;
    logic                    full;
    logic [`TTI_DEPTH_W-1:0] thld;
    logic                    thld_trig;
  } queue_stat_t;

endpackage

//--- source/tti_csr_access.sv
// CSR request decoder producing per-queue commands, interrupt clears and registered read data
`timescale 1ns/100ps
`include "tti_queue_consts.svh"

module tti_csr_access
  import tti_queue_pkg::*;
(
  input  logic                       hclk_i,
  input  logic                       rst_n_i,
  input  csr_req_t                   csr_req_i,
  output csr_rsp_t                   csr_rsp_o,
  input  queue_stat_t                q_stat_i [`TTI_QUEUE_NUM],
  input  logic [`TTI_QUEUE_NUM-1:0]  intr_i,
  output queue_cmd_t                 q_cmd_o [`TTI_QUEUE_NUM],
  output logic [`TTI_QUEUE_NUM-1:0]  intr_clr_o
);

  logic [1:0]             q_idx;
  csr_reg_e               reg_sel;
  logic                   wr_req;
  logic                   rd_req;
  logic [`TTI_DATA_W-1:0] rd_word;
  queue_stat_t            sel_stat;

  logic                   rd_ack_q;
  logic                   wr_ack_q;
  logic [`TTI_DATA_W-1:0] rd_data_q;

  assign q_idx   = csr_req_i.addr[5:4];
  assign reg_sel = csr_reg_e'(csr_req_i.addr[3:2]);
  assign wr_req  = csr_req_i.req & csr_req_i.we;
  assign rd_req  = csr_req_i.req & ~csr_req_i.we;

  // Per-queue commands, valid only in the request cycle
  always_comb begin
    intr_clr_o = '0;
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      q_cmd_o[q].op   = QOP_NONE;
      q_cmd_o[q].data = csr_req_i.wdata;
      if (wr_req && (q_idx == 2'(q))) begin
        case (reg_sel)
          REG_DATA:   q_cmd_o[q].op = QOP_PUSH;
          REG_THLD:   q_cmd_o[q].op = QOP_SET_THLD;
          REG_RST: begin
            if (csr_req_i.wdata[0]) begin
              q_cmd_o[q].op = QOP_FLUSH;
            end
          end
          REG_STATUS: intr_clr_o[q] = csr_req_i.wdata[`TTI_STAT_INTR_BIT];
          default:    q_cmd_o[q].op = QOP_NONE;
        endcase
      end
    end
  end

  assign sel_stat = q_stat_i[q_idx];

  // Read mux, DATA and RST read as zero
  always_comb begin
    rd_word = '0;
    case (reg_sel)
      REG_THLD: rd_word[`TTI_DEPTH_W-1:0] = sel_stat.thld;
      REG_STATUS: begin
        rd_word[`TTI_DEPTH_W-1:0]    = sel_stat.depth;
        rd_word[`TTI_STAT_EMPTY_BIT] = sel_stat.empty;
        rd_word[`TTI_STAT_FULL_BIT]  = sel_stat.full;
        rd_word[`TTI_STAT_TRIG_BIT]  = sel_stat.thld_trig;
        rd_word[`TTI_STAT_INTR_BIT]  = intr_i[q_idx];
      end
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_req;
      wr_ack_q <= wr_req;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (rd_req) begin
      rd_data_q <= rd_word;
    end
  end

  assign csr_rsp_o.rd_ack  = rd_ack_q;
  assign csr_rsp_o.wr_ack  = wr_ack_q;
  assign csr_rsp_o.rd_data = rd_data_q;

endmodule

//--- source/tti_queue.sv
// Single circular-buffer queue with depth count, ready threshold and trigger
`timescale 1ns/100ps
`include "tti_queue_consts.svh"

module tti_queue
  import tti_queue_pkg::*;
(
  input  logic                   hclk_i,
  input  logic                   rst_n_i,
  input  queue_cmd_t             cmd_i,
  input  logic                   pop_i,
  output queue_stat_t            stat_o,
  output logic [`TTI_DATA_W-1:0] head_o
);

  localparam int PTR_W = $clog2(`TTI_QUEUE_DEPTH);

  logic [`TTI_DATA_W-1:0]  mem [`TTI_QUEUE_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [`TTI_DEPTH_W-1:0] depth;
  logic [`TTI_DEPTH_W-1:0] thld;
  logic                    empty;
  logic                    full;
  logic                    do_push;
  logic                    do_pop;
  logic                    do_flush;

  assign empty    = (depth == '0);
  assign full     = (depth == `TTI_DEPTH_W'(`TTI_QUEUE_DEPTH));
  assign do_flush = (cmd_i.op == QOP_FLUSH);
  // Overflowing pushes and pops on empty are dropped
  assign do_push  = (cmd_i.op == QOP_PUSH) && !full;
  assign do_pop   = pop_i && !empty;

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      depth  <= '0;
    end else if (do_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      depth  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   depth <= depth + 1'b1;
        2'b01:   depth <= depth - 1'b1;
        default: depth <= depth;
      endcase
    end
  end

  always_ff @(posedge hclk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= cmd_i.data;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      thld <= `TTI_DEPTH_W'(`TTI_THLD_RST);
    end else if (cmd_i.op == QOP_SET_THLD) begin
      thld <= cmd_i.data[`TTI_DEPTH_W-1:0];
    end
  end

  assign head_o = mem[rd_ptr];

  assign stat_o.depth     = depth;
  assign stat_o.empty     = empty;
  assign stat_o.full      = full;
  assign stat_o.thld      = thld;
  // Zero threshold disables the trigger
  assign stat_o.thld_trig = (thld != '0) && (depth >= thld);

endmodule

//--- source/tti_intr_collect.sv
// Sticky per-queue threshold interrupts with write-one-to-clear and level interrupt line
`timescale 1ns/100ps
`include "tti_queue_consts.svh"

module tti_intr_collect
  import tti_queue_pkg::*;
(
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  queue_stat_t               q_stat_i [`TTI_QUEUE_NUM],
  input  logic [`TTI_QUEUE_NUM-1:0] intr_clr_i,
  output logic [`TTI_QUEUE_NUM-1:0] intr_o,
  output logic                      irq_o
);

  logic [`TTI_QUEUE_NUM-1:0] trig;
  logic [`TTI_QUEUE_NUM-1:0] trig_q;
  logic [`TTI_QUEUE_NUM-1:0] sticky_q;
  logic [`TTI_QUEUE_NUM-1:0] sticky_d;
  logic                      irq_q;

  always_comb begin
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      trig[q] = q_stat_i[q].thld_trig;
    end
  end

  // Rising edge sets, clear applied first so set wins
  assign sticky_d = (sticky_q & ~intr_clr_i) | (trig & ~trig_q);

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      trig_q   <= '0;
      sticky_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      trig_q   <= trig;
      sticky_q <= sticky_d;
      irq_q    <= |sticky_d;
    end
  end

  assign intr_o = sticky_q;
  assign irq_o  = irq_q;

endmodule

//--- source/tti_queues_top.sv
// Top level joining CSR access, the queue bank and the interrupt collector
`timescale 1ns/100ps
`include "tti_queue_consts.svh"

module tti_queues_top
  import tti_queue_pkg::*;
(
  input  logic                      hclk_i,
  input  logic                      rst_n_i,
  input  csr_req_t                  csr_req_i,
  output csr_rsp_t                  csr_rsp_o,
  input  logic [`TTI_QUEUE_NUM-1:0] pop_i,
  output queue_stat_t               q_stat_o [`TTI_QUEUE_NUM],
  output logic [`TTI_DATA_W-1:0]    q_head_o [`TTI_QUEUE_NUM],
  output logic                      irq_o
);

  queue_cmd_t                q_cmd [`TTI_QUEUE_NUM];
  queue_stat_t               q_stat [`TTI_QUEUE_NUM];
  logic [`TTI_QUEUE_NUM-1:0] intr;
  logic [`TTI_QUEUE_NUM-1:0] intr_clr;

  tti_csr_access xcsr_access (
    .hclk_i     (hclk_i),
    .rst_n_i    (rst_n_i),
    .csr_req_i  (csr_req_i),
    .csr_rsp_o  (csr_rsp_o),
    .q_stat_i   (q_stat),
    .intr_i     (intr),
    .q_cmd_o    (q_cmd),
    .intr_clr_o (intr_clr)
  );

  for (genvar i = 0; i < `TTI_QUEUE_NUM; i++) begin : g_queue
    tti_queue xqueue (
      .hclk_i  (hclk_i),
      .rst_n_i (rst_n_i),
      .cmd_i   (q_cmd[i]),
      .pop_i   (pop_i[i]),
      .stat_o  (q_stat[i]),
      .head_o  (q_head_o[i])
    );

    assign q_stat_o[i] = q_stat[i];
  end

  tti_intr_collect xintr_collect (
    .hclk_i     (hclk_i),
    .rst_n_i    (rst_n_i),
    .q_stat_i   (q_stat),
    .intr_clr_i (intr_clr),
    .intr_o     (intr),
    .irq_o      (irq_o)
  );

endmodule

//--- tests/tti_queues_tb.sv
// Directed testbench for the queue bank with CSR and pop drivers, compare tasks and timeout
`timescale 1ns/100ps
`include "tti_queue_consts.svh"

module tti_queues_tb
  import tti_queue_pkg::*;
;

  localparam int MAX_CYCLES = 2000;

  logic                      hclk;
  logic                      rst_n;
  csr_req_t                  csr_req;
  csr_rsp_t                  csr_rsp;
  logic [`TTI_QUEUE_NUM-1:0] pop;
  queue_stat_t               q_stat [`TTI_QUEUE_NUM];
  logic [`TTI_DATA_W-1:0]    q_head [`TTI_QUEUE_NUM];
  logic                      irq;

  int                      err_cnt;
  int                      cycle_cnt;
  logic [31:0]             rng_state;
  logic [`TTI_DATA_W-1:0]  model_data [`TTI_QUEUE_NUM][`TTI_QUEUE_DEPTH];
  int                      model_cnt [`TTI_QUEUE_NUM];
  logic [`TTI_DEPTH_W-1:0] model_thld [`TTI_QUEUE_NUM];

  tti_queues_top DUT (
    .hclk_i    (hclk),
    .rst_n_i   (rst_n),
    .csr_req_i (csr_req),
    .csr_rsp_o (csr_rsp),
    .pop_i     (pop),
    .q_stat_o  (q_stat),
    .q_head_o  (q_head),
    .irq_o     (irq)
  );

  initial begin
    hclk = 1'b0;
    forever #20 hclk = ~hclk;
  end

  always @(posedge hclk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("simulation timed out after %0d cycles, errors: %0d", cycle_cnt, err_cnt);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Expected status from the model count and threshold
  function automatic queue_stat_t expect_stat(input int q);
    queue_stat_t s;
    s.depth     = `TTI_DEPTH_W'(model_cnt[q]);
    s.empty     = (model_cnt[q] == 0);
    s.full      = (model_cnt[q] == `TTI_QUEUE_DEPTH);
    s.thld      = model_thld[q];
    s.thld_trig = (model_thld[q] != 0) && (model_cnt[q] >= model_thld[q]);
    return s;
  endfunction

  function automatic logic [`TTI_DATA_W-1:0] status_word(input int q, input logic intr);
    logic [`TTI_DATA_W-1:0] w;
    queue_stat_t            s;
    s = expect_stat(q);
    w = '0;
    w[`TTI_DEPTH_W-1:0]    = s.depth;
    w[`TTI_STAT_EMPTY_BIT] = s.empty;
    w[`TTI_STAT_FULL_BIT]  = s.full;
    w[`TTI_STAT_TRIG_BIT]  = s.thld_trig;
    w[`TTI_STAT_INTR_BIT]  = intr;
    return w;
  endfunction

  task automatic cmp_word(input string name, input logic [`TTI_DATA_W-1:0] got,
                          input logic [`TTI_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_stat(input string name, input queue_stat_t got, input queue_stat_t exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic cmp_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_all_stats();
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      cmp_stat($sformatf("q_stat_o[%0d]", q), q_stat[q], expect_stat(q));
    end
  endtask

  task automatic csr_write(input int q, input csr_reg_e sel, input logic [31:0] data);
    @(posedge hclk);
    #2;
    csr_req.req   = 1'b1;
    csr_req.we    = 1'b1;
    csr_req.addr  = {q[1:0], sel, 2'b00};
    csr_req.wdata = data;
    @(posedge hclk);
    #2;
    csr_req = '0;
    cmp_bit("wr_ack", csr_rsp.wr_ack, 1'b1);
    cmp_bit("rd_ack", csr_rsp.rd_ack, 1'b0);
  endtask

  task automatic csr_read(input int q, input csr_reg_e sel, output logic [31:0] data);
    @(posedge hclk);
    #2;
    csr_req.req  = 1'b1;
    csr_req.we   = 1'b0;
    csr_req.addr = {q[1:0], sel, 2'b00};
    @(posedge hclk);
    #2;
    csr_req = '0;
    if (csr_rsp.rd_ack !== 1'b1) begin
      $display("read acknowledge missing for queue %0d register %0d", q, sel);
      err_cnt++;
    end
    cmp_bit("wr_ack", csr_rsp.wr_ack, 1'b0);
    data = csr_rsp.rd_data;
  endtask

  task automatic push_word(input int q);
    logic [31:0] data;
    data = xorshift();
    csr_write(q, REG_DATA, data);
    // Model drops the word when full
    if (model_cnt[q] < `TTI_QUEUE_DEPTH) begin
      model_data[q][model_cnt[q]] = data;
      model_cnt[q]++;
    end
    cmp_stat($sformatf("q_stat_o[%0d]", q), q_stat[q], expect_stat(q));
  endtask

  task automatic pop_word(input int q);
    if (model_cnt[q] > 0) begin
      cmp_word($sformatf("q_head_o[%0d]", q), q_head[q], model_data[q][0]);
    end
    @(posedge hclk);
    #2;
    pop[q] = 1'b1;
    @(posedge hclk);
    #2;
    pop = '0;
    if (model_cnt[q] > 0) begin
      for (int i = 1; i < `TTI_QUEUE_DEPTH; i++) begin
        model_data[q][i-1] = model_data[q][i];
      end
      model_cnt[q]--;
    end
    cmp_stat($sformatf("q_stat_o[%0d]", q), q_stat[q], expect_stat(q));
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    check_all_stats();
    cmp_bit("irq_o", irq, 1'b0);
    cmp_bit("rd_ack", csr_rsp.rd_ack, 1'b0);
    cmp_bit("wr_ack", csr_rsp.wr_ack, 1'b0);
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      csr_read(q, REG_THLD, rd);
      cmp_word("rd_data", rd, `TTI_DATA_W'(`TTI_THLD_RST));
    end
  endtask

  task automatic test_fifo_order();
    logic [31:0] rd;
    // Zero threshold keeps the interrupt quiet here
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      csr_write(q, REG_THLD, 32'h0);
      model_thld[q] = '0;
    end
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      for (int i = 0; i < 5; i++) begin
        push_word(q);
      end
      csr_read(q, REG_STATUS, rd);
      cmp_word("rd_data", rd, status_word(q, 1'b0));
      while (model_cnt[q] > 0) begin
        pop_word(q);
      end
    end
    cmp_bit("irq_o", irq, 1'b0);
  endtask

  task automatic test_overflow();
    for (int i = 0; i < `TTI_QUEUE_DEPTH + 2; i++) begin
      push_word(1);
    end
    cmp_bit("q_stat_o[1].full", q_stat[1].full, 1'b1);
    for (int i = 0; i < `TTI_QUEUE_DEPTH; i++) begin
      pop_word(1);
    end
    pop_word(1);
  endtask

  task automatic test_threshold();
    logic [31:0] rd;
    csr_write(2, REG_THLD, 32'd3);
    model_thld[2] = 4'd3;
    push_word(2);
    push_word(2);
    cmp_bit("irq_o", irq, 1'b0);
    push_word(2);
    cmp_bit("irq_o", irq, 1'b0);
    // Sticky bit lands one cycle after the trigger rises
    @(posedge hclk);
    #2;
    cmp_bit("irq_o", irq, 1'b1);
    csr_read(2, REG_STATUS, rd);
    cmp_word("rd_data", rd, status_word(2, 1'b1));
    csr_write(2, REG_STATUS, 32'h1 << `TTI_STAT_INTR_BIT);
    cmp_bit("irq_o", irq, 1'b0);
    repeat (4) @(posedge hclk);
    #2;
    cmp_bit("irq_o", irq, 1'b0);
    csr_read(2, REG_STATUS, rd);
    cmp_word("rd_data", rd, status_word(2, 1'b0));
  endtask

  task automatic test_flush();
    for (int i = 0; i < 2; i++) begin
      push_word(0);
    end
    for (int i = 0; i < 4; i++) begin
      push_word(3);
    end
    csr_write(3, REG_RST, 32'h1);
    model_cnt[3] = 0;
    check_all_stats();
  endtask

  initial begin
    rst_n     = 1'b0;
    csr_req   = '0;
    pop       = '0;
    err_cnt   = 0;
    cycle_cnt = 0;
    rng_state = 32'h12ed6cd2;
    for (int q = 0; q < `TTI_QUEUE_NUM; q++) begin
      model_cnt[q]  = 0;
      model_thld[q] = `TTI_DEPTH_W'(`TTI_THLD_RST);
    end
    repeat (3) @(posedge hclk);
    #2;
    rst_n = 1'b1;

    test_reset();
    test_fifo_order();
    test_overflow();
    test_threshold();
    test_flush();

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
source/tti_queue_pkg.sv
source/tti_csr_access.sv
source/tti_queue.sv
source/tti_intr_collect.sv
source/tti_queues_top.sv
tests/tti_queues_tb.sv
